/* mem_params.svh */
`default_nettype none

`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Word and line geometry
`define XLEN        32
`define LINE_WORDS  4

// Unified line memory
`define MEM_LINES   1024
`define MEM_LATENCY 3    // Cycles from accepted req to valid

// Direct-mapped cache sizes
`define ICACHE_SETS 16
`define DCACHE_SETS 16

`endif

`default_nettype wire

/* mem_types_pkg.sv */
`include "mem_params.svh"
`default_nettype none

package mem_types_pkg;

    typedef logic [`XLEN-1:0]              word_t;
    typedef logic [`LINE_WORDS*`XLEN-1:0]  line_t;      // Word 0 in the low bits
    typedef logic [$clog2(`MEM_LINES)-1:0] line_idx_t;
    typedef logic [$clog2(`LINE_WORDS)-1:0] word_off_t;
    typedef logic [$bits(line_idx_t)+$bits(word_off_t)-1:0] word_addr_t;

    // Split a word address into line index and word offset
    function automatic line_idx_t line_of(word_addr_t a);
        return a[$bits(word_addr_t)-1:$bits(word_off_t)];
    endfunction

    function automatic word_off_t offset_of(word_addr_t a);
        return a[$bits(word_off_t)-1:0];
    endfunction

    function automatic word_t get_word(line_t l, word_off_t o);
        return l[o*`XLEN +: `XLEN];
    endfunction

    // Replace one word of a line
    function automatic line_t put_word(line_t l, word_off_t o, word_t w);
        line_t r;
        r = l;
        r[o*`XLEN +: `XLEN] = w;
        return r;
    endfunction

endpackage

`default_nettype wire

/* cache_ctrl_pkg.sv */
`default_nettype none

package cache_ctrl_pkg;

    // Instruction cache controller
    typedef enum logic [0:0] {
        IC_IDLE,
        IC_FILL   // Waiting for the line from memory
    } icache_state_e;

    // Data cache controller
    typedef enum logic [1:0] {
        DC_IDLE,
        DC_WRITEBACK, // Dirty victim pulsed out, fill next
        DC_FILL
    } dcache_state_e;

endpackage

`default_nettype wire

/* line_fill_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Line fill channel between one cache and the unified memory
interface line_fill_if
    import mem_types_pkg::*;
();

    logic      req;    // One-cycle request pulse
    line_idx_t addr;   // Line to fetch
    line_t     line;   // Held until the next fill completes
    logic      valid;  // One-cycle completion pulse

    modport cache (
        output req,
        output addr,
        input  line,
        input  valid
    );

    modport memory (
        input  req,
        input  addr,
        output line,
        output valid
    );

endinterface

`default_nettype wire

/* unified_mem.sv */
`include "mem_params.svh"
`timescale 1ns/1ps
`default_nettype none

module unified_mem
    import mem_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    line_fill_if.memory ifill,
    line_fill_if.memory dfill,
    input  logic      wb_we,
    input  line_idx_t wb_addr,
    input  line_t     wb_line
);

    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);
    localparam int SIDES = 2;  // 0 is fetch, 1 is data

    line_t mem [`MEM_LINES];

    // Per-side fill pipeline state
    logic [SIDES-1:0] side_req;
    line_idx_t        side_addr [SIDES];
    logic [CNT_W-1:0] cnt [SIDES];
    line_idx_t        saved [SIDES];
    line_t            line_q [SIDES];
    logic [SIDES-1:0] valid_q;

    initial begin
        for (int i = 0; i < `MEM_LINES; i++) begin
            mem[i] = '0;
        end
    end

    assign side_req[0]  = ifill.req;
    assign side_addr[0] = ifill.addr;
    assign side_req[1]  = dfill.req;
    assign side_addr[1] = dfill.addr;

    assign ifill.line  = line_q[0];
    assign ifill.valid = valid_q[0];
    assign dfill.line  = line_q[1];
    assign dfill.valid = valid_q[1];

    // Counters and valid pulses
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            for (int s = 0; s < SIDES; s++) begin
                cnt[s] <= '0;
            end
        end else begin
            valid_q <= '0;
            for (int s = 0; s < SIDES; s++) begin
                if (side_req[s] && cnt[s] == '0) begin
                    cnt[s] <= CNT_W'(`MEM_LATENCY);  // Only accepted when idle
                end
                if (cnt[s] != '0) begin
                    cnt[s] <= cnt[s] - 1'b1;
                    if (cnt[s] == CNT_W'(1)) begin
                        valid_q[s] <= 1'b1;
                    end
                end
            end
        end
    end

    // Captured index and delivered line
    always_ff @(posedge clk) begin
        for (int s = 0; s < SIDES; s++) begin
            if (side_req[s] && cnt[s] == '0) begin
                saved[s] <= side_addr[s];
            end
            if (cnt[s] == CNT_W'(1)) begin
                line_q[s] <= mem[saved[s]];
            end
        end
    end

    // Whole-line write-back from the data cache
    always @(posedge clk) begin
        if (wb_we) begin
            mem[wb_addr] <= wb_line;
        end
    end

endmodule

`default_nettype wire

/* icache.sv */
`include "mem_params.svh"
`timescale 1ns/1ps
`default_nettype none

module icache
    import mem_types_pkg::*, cache_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       req,
    input  word_addr_t addr,
    output word_t      inst,
    output logic       done,
    line_fill_if.cache fill
);

    localparam int LW    = $bits(line_idx_t);
    localparam int SET_W = $clog2(`ICACHE_SETS);
    localparam int TAG_W = LW - SET_W;

    icache_state_e state;

    logic [TAG_W-1:0]        tags [`ICACHE_SETS];
    line_t                   lines [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0] vld;

    line_idx_t        req_line;
    word_off_t        req_off;
    logic [SET_W-1:0] req_set;
    logic [TAG_W-1:0] req_tag;
    logic             hit;

    line_idx_t        miss_line;  // Line being filled
    word_off_t        miss_off;
    logic [SET_W-1:0] miss_set;
    logic [TAG_W-1:0] miss_tag;
    logic             fill_req;

    assign req_line = line_of(addr);
    assign req_off  = offset_of(addr);
    assign req_set  = req_line[SET_W-1:0];
    assign req_tag  = req_line[LW-1:SET_W];
    assign hit      = vld[req_set] && (tags[req_set] == req_tag);

    assign miss_set = miss_line[SET_W-1:0];
    assign miss_tag = miss_line[LW-1:SET_W];

    assign fill.req  = fill_req;
    assign fill.addr = miss_line;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IC_IDLE;
            done     <= 1'b0;
            fill_req <= 1'b0;
            vld      <= '0;
        end else begin
            done     <= 1'b0;
            fill_req <= 1'b0;
            case (state)
                IC_IDLE: begin
                    if (req) begin
                        if (hit) begin
                            done <= 1'b1;
                        end else begin
                            fill_req <= 1'b1;
                            state    <= IC_FILL;
                        end
                    end
                end
                IC_FILL: begin
                    if (fill.valid) begin  // Install and answer together
                        vld[miss_set] <= 1'b1;
                        done          <= 1'b1;
                        state         <= IC_IDLE;
                    end
                end
                default: state <= IC_IDLE;
            endcase
        end
    end

    // Line storage and fetch word
    always_ff @(posedge clk) begin
        if (state == IC_IDLE && req) begin
            miss_line <= req_line;
            miss_off  <= req_off;
            if (hit) begin
                inst <= get_word(lines[req_set], req_off);
            end
        end
        if (state == IC_FILL && fill.valid) begin
            tags[miss_set]  <= miss_tag;
            lines[miss_set] <= fill.line;
            inst            <= get_word(fill.line, miss_off);
        end
    end

endmodule

`default_nettype wire

/* dcache.sv */
`include "mem_params.svh"
`timescale 1ns/1ps
`default_nettype none

module dcache
    import mem_types_pkg::*, cache_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       req,
    input  logic       we,
    input  word_addr_t addr,
    input  word_t      wdata,
    output word_t      rdata,
    output logic       done,
    line_fill_if.cache fill,
    output logic       wb_we,
    output line_idx_t  wb_addr,
    output line_t      wb_line
);

    localparam int LW    = $bits(line_idx_t);
    localparam int SET_W = $clog2(`DCACHE_SETS);
    localparam int TAG_W = LW - SET_W;

    dcache_state_e state;

    logic [TAG_W-1:0]        tags [`DCACHE_SETS];
    line_t                   lines [`DCACHE_SETS];
    logic [`DCACHE_SETS-1:0] vld;
    logic [`DCACHE_SETS-1:0] dirty;

    line_idx_t        req_line;
    word_off_t        req_off;
    logic [SET_W-1:0] req_set;
    logic [TAG_W-1:0] req_tag;
    logic             hit;
    logic             victim_dirty;

    // Saved request while a miss is in flight
    line_idx_t        miss_line;
    word_off_t        miss_off;
    logic             miss_we;
    word_t            miss_wdata;
    logic [SET_W-1:0] miss_set;
    logic [TAG_W-1:0] miss_tag;

    logic fill_req;
    logic wb_we_q;

    assign req_line     = line_of(addr);
    assign req_off      = offset_of(addr);
    assign req_set      = req_line[SET_W-1:0];
    assign req_tag      = req_line[LW-1:SET_W];
    assign hit          = vld[req_set] && (tags[req_set] == req_tag);
    assign victim_dirty = vld[req_set] && dirty[req_set];

    assign miss_set = miss_line[SET_W-1:0];
    assign miss_tag = miss_line[LW-1:SET_W];

    assign fill.req  = fill_req;
    assign fill.addr = miss_line;

    // Victim stays in its set until the fill lands
    assign wb_we   = wb_we_q;
    assign wb_addr = {tags[miss_set], miss_set};
    assign wb_line = lines[miss_set];

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= DC_IDLE;
            done     <= 1'b0;
            fill_req <= 1'b0;
            wb_we_q  <= 1'b0;
            vld      <= '0;
            dirty    <= '0;
        end else begin
            done     <= 1'b0;
            fill_req <= 1'b0;
            wb_we_q  <= 1'b0;
            case (state)
                DC_IDLE: begin
                    if (req) begin
                        if (hit) begin
                            done <= 1'b1;
                            if (we) begin
                                dirty[req_set] <= 1'b1;
                            end
                        end else if (victim_dirty) begin
                            wb_we_q <= 1'b1;
                            state   <= DC_WRITEBACK;
                        end else begin
                            fill_req <= 1'b1;
                            state    <= DC_FILL;
                        end
                    end
                end
                DC_WRITEBACK: begin
                    fill_req <= 1'b1;  // One cycle after the write-back pulse
                    state    <= DC_FILL;
                end
                DC_FILL: begin
                    if (fill.valid) begin
                        vld[miss_set]   <= 1'b1;
                        dirty[miss_set] <= miss_we;  // Store miss leaves the line dirty
                        done            <= 1'b1;
                        state           <= DC_IDLE;
                    end
                end
                default: state <= DC_IDLE;
            endcase
        end
    end

    // Line storage, store merge and load data
    always_ff @(posedge clk) begin
        if (state == DC_IDLE && req) begin
            miss_line  <= req_line;
            miss_off   <= req_off;
            miss_we    <= we;
            miss_wdata <= wdata;
            if (hit) begin
                if (we) begin
                    lines[req_set] <= put_word(lines[req_set], req_off, wdata);
                end else begin
                    rdata <= get_word(lines[req_set], req_off);
                end
            end
        end
        if (state == DC_FILL && fill.valid) begin
            tags[miss_set] <= miss_tag;
            if (miss_we) begin
                lines[miss_set] <= put_word(fill.line, miss_off, miss_wdata);
            end else begin
                lines[miss_set] <= fill.line;
                rdata           <= get_word(fill.line, miss_off);
            end
        end
    end

endmodule

`default_nettype wire

/* mem_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsys
    import mem_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // Fetch side
    input  logic       if_req,
    input  word_addr_t if_addr,
    output word_t      if_inst,
    output logic       if_done,

    // Load/store side
    input  logic       d_req,
    input  logic       d_we,
    input  word_addr_t d_addr,
    input  word_t      d_wdata,
    output word_t      d_rdata,
    output logic       d_done
);

    line_fill_if ifill ();
    line_fill_if dfill ();

    // Victim write-back path
    logic      wb_we;
    line_idx_t wb_addr;
    line_t     wb_line;

    icache ic0 (
        .clk  (clk),
        .rst  (rst),
        .req  (if_req),
        .addr (if_addr),
        .inst (if_inst),
        .done (if_done),
        .fill (ifill)
    );

    dcache dc0 (
        .clk     (clk),
        .rst     (rst),
        .req     (d_req),
        .we      (d_we),
        .addr    (d_addr),
        .wdata   (d_wdata),
        .rdata   (d_rdata),
        .done    (d_done),
        .fill    (dfill),
        .wb_we   (wb_we),
        .wb_addr (wb_addr),
        .wb_line (wb_line)
    );

    unified_mem mem0 (
        .clk     (clk),
        .rst     (rst),
        .ifill   (ifill),
        .dfill   (dfill),
        .wb_we   (wb_we),
        .wb_addr (wb_addr),
        .wb_line (wb_line)
    );

endmodule

`default_nettype wire

/* mem_subsys_props.sv */
`include "mem_params.svh"
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_props (
    input logic clk,
    input logic rst,
    input logic if_done,
    input logic d_done,
    input logic ifill_req,
    input logic ifill_valid,
    input logic dfill_req,
    input logic dfill_valid,
    input logic wb_we
);

    logic i_busy;  // Fetch-side fill in flight
    logic d_busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            i_busy <= 1'b0;
            d_busy <= 1'b0;
        end else begin
            if (ifill_req) begin
                i_busy <= 1'b1;
            end else if (ifill_valid) begin
                i_busy <= 1'b0;
            end
            if (dfill_req) begin
                d_busy <= 1'b1;
            end else if (dfill_valid) begin
                d_busy <= 1'b0;
            end
        end
    end

    a_if_done_pulse: assert property (@(posedge clk) disable iff (rst)
        if_done |-> !$past(if_done))
        else $error("if_done high for more than one cycle");

    a_d_done_pulse: assert property (@(posedge clk) disable iff (rst)
        d_done |-> !$past(d_done))
        else $error("d_done high for more than one cycle");

    a_ifill_one_out: assert property (@(posedge clk) disable iff (rst)
        ifill_req |-> !i_busy)
        else $error("fetch-side fill req while a fill is outstanding");

    a_dfill_one_out: assert property (@(posedge clk) disable iff (rst)
        dfill_req |-> !d_busy)
        else $error("data-side fill req while a fill is outstanding");

    a_wb_vs_fill: assert property (@(posedge clk) disable iff (rst)
        !(wb_we && dfill_req))
        else $error("wb_we and dfill.req high in the same cycle");

    // Memory takes req at the edge it is seen, valid rises MEM_LATENCY edges later
    a_ifill_latency: assert property (@(posedge clk) disable iff (rst)
        ifill_valid |-> $past(ifill_req, `MEM_LATENCY + 1))
        else $error("fetch-side fill valid at the wrong distance from req");

    a_dfill_latency: assert property (@(posedge clk) disable iff (rst)
        dfill_valid |-> $past(dfill_req, `MEM_LATENCY + 1))
        else $error("data-side fill valid at the wrong distance from req");

endmodule

bind mem_subsys mem_subsys_props props0 (
    .clk         (clk),
    .rst         (rst),
    .if_done     (if_done),
    .d_done      (d_done),
    .ifill_req   (ifill.req),
    .ifill_valid (ifill.valid),
    .dfill_req   (dfill.req),
    .dfill_valid (dfill.valid),
    .wb_we       (wb_we)
);

`default_nettype wire

/* tb_mem_subsys.sv */
`include "mem_params.svh"
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys
    import mem_types_pkg::*;
();

    localparam int PERIOD        = 40;
    localparam int DRIVE_DLY     = 2;
    localparam int RESET_CYCLES  = 8;
    localparam int unsigned SEED = 32'h9ef636be;
    localparam int LW            = `LINE_WORDS;
    localparam int ICS           = `ICACHE_SETS;
    localparam int DCS           = `DCACHE_SETS;
    // Raise fill req, memory accepts, latency, then done
    localparam int MISS_LAT      = `MEM_LATENCY + 3;
    localparam int DONE_BOUND    = 4 * MISS_LAT;
    localparam int DIRECTED_REQS = 11;
    localparam int RANDOM_OPS    = 400;
    localparam int WORST_CYCLES  = MISS_LAT + 2;  // Dirty miss plus idle gap
    localparam int TIMEOUT_NS    = 2 * PERIOD *
        (RESET_CYCLES + 10 + (DIRECTED_REQS + RANDOM_OPS) * WORST_CYCLES);

    logic       clk;
    logic       rst;
    logic       if_req;
    word_addr_t if_addr;
    word_t      if_inst;
    logic       if_done;
    logic       d_req;
    logic       d_we;
    word_addr_t d_addr;
    word_t      d_wdata;
    word_t      d_rdata;
    logic       d_done;

    // Reference model state
    word_t mem_m [`MEM_LINES * LW];
    logic  ic_v [ICS];
    int    ic_line [ICS];
    word_t ic_d [ICS][LW];
    logic  dc_v [DCS];
    logic  dc_dirty [DCS];
    int    dc_line [DCS];
    word_t dc_d [DCS][LW];

    mem_subsys dut0 (
        .clk     (clk),
        .rst     (rst),
        .if_req  (if_req),
        .if_addr (if_addr),
        .if_inst (if_inst),
        .if_done (if_done),
        .d_req   (d_req),
        .d_we    (d_we),
        .d_addr  (d_addr),
        .d_wdata (d_wdata),
        .d_rdata (d_rdata),
        .d_done  (d_done)
    );

    always #(PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            abort_run($sformatf("MISMATCH %s expected 0x%08h actual 0x%08h", name, exp, act));
        end
    endtask

    function automatic void model_reset();
        for (int i = 0; i < `MEM_LINES * LW; i++) begin
            mem_m[i] = '0;
        end
        for (int s = 0; s < ICS; s++) begin
            ic_v[s] = 1'b0;
        end
        for (int s = 0; s < DCS; s++) begin
            dc_v[s]     = 1'b0;
            dc_dirty[s] = 1'b0;
        end
    endfunction

    // Fetch side never sees data-cache stores until a write-back
    function automatic void model_fetch(input int a, output word_t w, output int lat);
        int line;
        int set;
        line = a / LW;
        set  = line % ICS;
        if (ic_v[set] && ic_line[set] == line) begin
            lat = 1;
        end else begin
            for (int k = 0; k < LW; k++) begin
                ic_d[set][k] = mem_m[line * LW + k];
            end
            ic_v[set]    = 1'b1;
            ic_line[set] = line;
            lat          = MISS_LAT;
        end
        w = ic_d[set][a % LW];
    endfunction

    function automatic void model_access(input logic we, input int a, input word_t wd,
                                         output word_t w, output int lat);
        int line;
        int set;
        line = a / LW;
        set  = line % DCS;
        if (dc_v[set] && dc_line[set] == line) begin
            lat = 1;
        end else begin
            lat = MISS_LAT;
            if (dc_v[set] && dc_dirty[set]) begin
                for (int k = 0; k < LW; k++) begin
                    mem_m[dc_line[set] * LW + k] = dc_d[set][k];
                end
                lat++;  // Extra cycle for the victim
            end
            for (int k = 0; k < LW; k++) begin
                dc_d[set][k] = mem_m[line * LW + k];
            end
            dc_v[set]     = 1'b1;
            dc_dirty[set] = 1'b0;
            dc_line[set]  = line;
        end
        if (we) begin
            dc_d[set][a % LW] = wd;
            dc_dirty[set]     = 1'b1;
        end
        w = dc_d[set][a % LW];
    endfunction

    // Count edges from the request to the done pulse
    task automatic wait_for_done(input logic data_side, input string name, output int lat);
        logic seen;
        lat  = 0;
        seen = 1'b0;
        while (!seen) begin
            @(posedge clk);
            #DRIVE_DLY;
            if_req = 1'b0;
            d_req  = 1'b0;
            lat++;
            seen = data_side ? d_done : if_done;
            if (!seen && lat >= DONE_BOUND) begin
                abort_run($sformatf("%s: no done pulse within %0d cycles", name, DONE_BOUND));
            end
        end
    endtask

    task automatic run_fetch(input word_addr_t a, input string name);
        word_t exp_w;
        int    exp_lat;
        int    lat;
        model_fetch(int'(a), exp_w, exp_lat);
        if_addr = a;
        if_req  = 1'b1;
        wait_for_done(1'b0, name, lat);
        check_value({name, " latency"}, exp_lat, lat);
        check_value({name, " if_inst"}, exp_w, if_inst);
        @(posedge clk);  // Idle gap keeps done a single pulse
        #DRIVE_DLY;
    endtask

    task automatic run_data(input logic we, input word_addr_t a, input word_t wd,
                            input string name);
        word_t exp_w;
        int    exp_lat;
        int    lat;
        model_access(we, int'(a), wd, exp_w, exp_lat);
        d_we    = we;
        d_addr  = a;
        d_wdata = wd;
        d_req   = 1'b1;
        wait_for_done(1'b1, name, lat);
        check_value({name, " latency"}, exp_lat, lat);
        if (!we) begin
            check_value({name, " d_rdata"}, exp_w, d_rdata);
        end
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // Two sets, four tags each, so conflicts are frequent
    function automatic word_addr_t random_addr();
        int line;
        line = int'($urandom % 4) * DCS + int'($urandom % 2);
        return word_addr_t'(line * LW + int'($urandom % LW));
    endfunction

    initial begin
        #TIMEOUT_NS;
        abort_run($sformatf("Watchdog expired after %0d ns, the run did not finish", TIMEOUT_NS));
    end

    initial begin
        int         kind;
        word_addr_t ra;
        word_t      rw;
        void'($urandom(SEED));
        clk     = 1'b0;
        rst     = 1'b1;
        if_req  = 1'b0;
        if_addr = '0;
        d_req   = 1'b0;
        d_we    = 1'b0;
        d_addr  = '0;
        d_wdata = '0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;

        // Quiet outputs before any request
        repeat (4) begin
            check_value("idle if_done", 32'd0, {31'd0, if_done});
            check_value("idle d_done", 32'd0, {31'd0, d_done});
            @(posedge clk);
            #DRIVE_DLY;
        end

        run_fetch(12'h040, "fetch untouched");
        run_fetch(12'h041, "fetch same line");

        run_data(1'b1, 12'h100, 32'hcafe0001, "store word");
        run_data(1'b0, 12'h100, '0, "load stored word");

        // Same data set, second store evicts the first line dirty
        run_data(1'b1, 12'h104, 32'h1234abcd, "store set1 a");
        run_data(1'b1, 12'h144, 32'h5a5a0f0f, "store set1 b");
        run_data(1'b0, 12'h104, '0, "load after victim");

        run_fetch(12'h104, "fetch written-back line");
        run_data(1'b1, 12'h040, 32'hdeadbeef, "store over fetched line");
        run_data(1'b1, 12'h080, 32'h00c0ffee, "evict to memory");
        run_fetch(12'h040, "fetch stale line");

        for (int i = 0; i < RANDOM_OPS; i++) begin
            kind = int'($urandom % 3);
            ra   = random_addr();
            rw   = $urandom;
            case (kind)
                0: run_fetch(ra, $sformatf("random fetch %0d", i));
                1: run_data(1'b0, ra, '0, $sformatf("random load %0d", i));
                default: run_data(1'b1, ra, rw, $sformatf("random store %0d", i));
            endcase
        end

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
mem_types_pkg.sv
cache_ctrl_pkg.sv
line_fill_if.sv
unified_mem.sv
icache.sv
dcache.sv
mem_subsys.sv
mem_subsys_props.sv
tb_mem_subsys.sv

/* Makefile */
TOP = tb_mem_subsys

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o $(TOP)
	-./obj_dir/$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
